// ==== hw/current_pi_loop.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module current_pi_loop (
  input  logic                     sys_clk_i,
  input  logic                     reset_i,
  input  logic                     loop_enable_i,   // integrators held clear when low
  input  logic                     sample_valid_i,
  input  pmsm_pkg::phase_current_t current_i,       // measured a/b
  input  pmsm_pkg::phase_current_t current_set_i,   // demanded a/b
  input  pmsm_pkg::pi_gain_t       gains_i,
  output pmsm_pkg::phase_duty_t    duty_o,
  output logic                     duty_valid_o
);

  localparam int ACC_W = 32;  // headroom for err * gain

  logic signed [ACC_W-1:0] kp;
  logic signed [ACC_W-1:0] ki;
  logic signed [ACC_W-1:0] err     [2];  // index 0 = a, 1 = b
  logic signed [ACC_W-1:0] prop_d  [2];
  logic signed [ACC_W-1:0] integ_d [2];
  logic signed [ACC_W-1:0] prop_q  [2];
  logic signed [ACC_W-1:0] integ_q [2];
  logic signed [ACC_W-1:0] volt    [3];
  logic                    valid_q;      // stage 1 result ready

  function automatic logic signed [ACC_W-1:0] sat_integ(input logic signed [ACC_W-1:0] x);
    if (x > `INTEG_LIMIT)
      return `INTEG_LIMIT;
    if (x < -`INTEG_LIMIT)
      return -`INTEG_LIMIT;
    return x;
  endfunction

  function automatic pmsm_pkg::duty_t clamp_duty(input logic signed [ACC_W-1:0] v);
    logic signed [ACC_W-1:0] d;
    d = v + `PWM_HALF;
    if (d < 0)
      return '0;
    if (d > `PWM_PERIOD)
      return pmsm_pkg::duty_t'(`PWM_PERIOD);
    return pmsm_pkg::duty_t'(d);
  endfunction

  assign kp     = ACC_W'($signed({1'b0, gains_i.kp}));
  assign ki     = ACC_W'($signed({1'b0, gains_i.ki}));
  assign err[0] = ACC_W'($signed(current_set_i.a)) - ACC_W'($signed(current_i.a));
  assign err[1] = ACC_W'($signed(current_set_i.b)) - ACC_W'($signed(current_i.b));

  //====================================================================
  // stage 1: error, p term, saturating integrator
  //====================================================================
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      prop_d[i]  = err[i] * kp;
      integ_d[i] = sat_integ(integ_q[i] + err[i] * ki);
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (reset_i || !loop_enable_i) begin
      integ_q[0] <= '0;
      integ_q[1] <= '0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= sample_valid_i;
      if (sample_valid_i) begin
        integ_q[0] <= integ_d[0];
        integ_q[1] <= integ_d[1];
      end
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (sample_valid_i)
      prop_q <= prop_d;
  end

  //====================================================================
  // stage 2: scale, derive phase c, clamp to period
  //====================================================================
  always_comb begin
    volt[0] = (prop_q[0] + integ_q[0]) >>> `GAIN_SHIFT;
    volt[1] = (prop_q[1] + integ_q[1]) >>> `GAIN_SHIFT;
    volt[2] = -(volt[0] + volt[1]);  // three phases sum to zero
  end

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      duty_o       <= {3{pmsm_pkg::duty_t'(`PWM_HALF)}};  // zero volts
      duty_valid_o <= 1'b0;
    end else begin
      duty_valid_o <= valid_q;
      if (valid_q) begin
        duty_o.a <= clamp_duty(volt[0]);
        duty_o.b <= clamp_duty(volt[1]);
        duty_o.c <= clamp_duty(volt[2]);
      end
    end
  end

endmodule

// ==== hw/current_sense_adc.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module current_sense_adc (
  input  logic            sys_clk_i,
  input  logic            reset_i,
  input  logic            sample_start_i,  // start one conversion
  input  logic            sdata_i,         // sensor serial data
  input  logic            ocd_n_i,         // sensor fast overcurrent, low active
  output logic            sclk_o,
  output logic            cs_n_o,
  output pmsm_pkg::data_t current_o,       // code minus midscale
  output logic            sample_valid_o,
  output logic            overcurrent_o
);

  localparam int DIV_W = $clog2(`SCLK_HALF + 1);
  localparam int BIT_W = $clog2(`ADC_FRAME_BITS + 1);
  localparam logic signed [`ADC_BITS:0] MID = `ADC_MIDSCALE;

  logic                        busy_q;      // frame in progress
  logic                        done_q;      // last falling sclk seen
  logic                        ocd_n_q;     // registered ocd pin
  logic [DIV_W-1:0]            div_q;       // sclk half-period divider
  logic [BIT_W-1:0]            bit_cnt_q;   // rising edges so far
  logic [`ADC_BITS-1:0]        shift_q;     // leading zeros fall off the top
  logic signed [`ADC_BITS:0]   offset_code;
  logic [`ADC_BITS:0]          magnitude;
  logic                        half_tick;

  assign half_tick   = busy_q && (div_q == DIV_W'(`SCLK_HALF - 1));
  assign offset_code = $signed({1'b0, shift_q}) - MID;
  assign magnitude   = (offset_code < 0) ? -offset_code : offset_code;

  //====================================================================
  // frame timing
  //====================================================================
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      busy_q         <= 1'b0;
      done_q         <= 1'b0;
      ocd_n_q        <= 1'b1;
      div_q          <= '0;
      bit_cnt_q      <= '0;
      sclk_o         <= 1'b0;  // idles low
      cs_n_o         <= 1'b1;
      sample_valid_o <= 1'b0;
      overcurrent_o  <= 1'b0;
    end else begin
      ocd_n_q        <= ocd_n_i;
      done_q         <= 1'b0;
      sample_valid_o <= done_q;  // result lands one cycle after frame end
      overcurrent_o  <= (done_q && (magnitude > `IMAX_CODE)) || !ocd_n_q;
      if (done_q)
        cs_n_o <= 1'b1;  // deselect after the final falling edge
      if (sample_start_i && !busy_q) begin
        busy_q    <= 1'b1;
        cs_n_o    <= 1'b0;
        div_q     <= '0;
        bit_cnt_q <= '0;
      end else if (busy_q) begin
        div_q <= half_tick ? '0 : div_q + 1'b1;
        if (half_tick) begin
          sclk_o <= !sclk_o;
          if (!sclk_o) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;  // rising edge
          end else if (bit_cnt_q == BIT_W'(`ADC_FRAME_BITS)) begin
            busy_q <= 1'b0;  // last falling edge, frame done
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // sample on the rising sclk, sensor moves data on the falling one
  always_ff @(posedge sys_clk_i) begin
    if (half_tick && !sclk_o)
      shift_q <= {shift_q[`ADC_BITS-2:0], sdata_i};
  end

  always_ff @(posedge sys_clk_i) begin
    if (done_q)
      current_o <= pmsm_pkg::data_t'(offset_code);  // sign extended
  end

  // sclk only moves while the sensor is selected
  a_sclk_in_frame: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    $changed(sclk_o) |-> !cs_n_o);

endmodule

// ==== hw/dead_time_inserter.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module dead_time_inserter (
  input  logic sys_clk_i,
  input  logic reset_i,
  input  logic demand_i,  // 1 = high side wanted
  output logic high_o,
  output logic low_o
);

  localparam int CNT_W = $clog2(`DEAD_TIME + 1);

  logic             demand_q;    // side currently granted
  logic [CNT_W-1:0] dead_cnt_q;  // off-time remaining

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      demand_q   <= 1'b0;
      dead_cnt_q <= '0;
      high_o     <= 1'b0;
      low_o      <= 1'b1;  // low side parked on
    end else if (demand_i != demand_q) begin
      demand_q   <= demand_i;
      dead_cnt_q <= CNT_W'(`DEAD_TIME);
      high_o     <= 1'b0;  // both off at every switch
      low_o      <= 1'b0;
    end else if (dead_cnt_q != '0) begin
      dead_cnt_q <= dead_cnt_q - 1'b1;
      if (dead_cnt_q == CNT_W'(1)) begin
        high_o <= demand_q;
        low_o  <= !demand_q;
      end
    end
  end

  // any switch-on is preceded by a full dead window with both off
  a_dead_gap: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    ($rose(high_o) || $rose(low_o)) |->
      !(high_o && low_o) && $past(!high_o && !low_o, `DEAD_TIME));

endmodule

// ==== hw/pmsm_control_unit.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module pmsm_control_unit (
  input  logic sys_clk_i,
  input  logic reset_i,
  input  logic period_start_i,  // pwm period boundary
  input  logic overcurrent_i,   // either sensor over limit
  input  logic drv_nfault_i,    // driver fault, low active
  output logic drv_enable_o,    // gate driver power
  output logic loop_enable_o,   // current loop + pwm run
  output logic sample_start_o,  // kicks both sensor readers
  output logic brake_o,         // band brake engaged
  output logic fault_o
);

  localparam int CNT_W = $clog2(`INIT_CYCLES);

  pmsm_pkg::ctrl_state_e state_q;
  pmsm_pkg::ctrl_state_e state_d;
  logic [CNT_W-1:0]      init_cnt_q;  // driver wake-up timer
  logic                  fault_hit;

  assign fault_hit = overcurrent_i || !drv_nfault_i;

  //====================================================================
  // sequencer
  //====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      pmsm_pkg::IDLE: state_d = pmsm_pkg::DRIVER_INIT;  // power up at once
      pmsm_pkg::DRIVER_INIT: begin
        if (fault_hit)
          state_d = pmsm_pkg::FAULT;
        else if (init_cnt_q == CNT_W'(`INIT_CYCLES - 1))
          state_d = pmsm_pkg::RUN;
      end
      pmsm_pkg::RUN: begin
        if (fault_hit)
          state_d = pmsm_pkg::FAULT;
      end
      default: state_d = pmsm_pkg::FAULT;  // only reset leaves
    endcase
  end

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state_q    <= pmsm_pkg::IDLE;
      init_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == pmsm_pkg::DRIVER_INIT)
        init_cnt_q <= init_cnt_q + 1'b1;  // counts only while waiting
      else
        init_cnt_q <= '0;
    end
  end

  assign drv_enable_o   = (state_q == pmsm_pkg::DRIVER_INIT) || (state_q == pmsm_pkg::RUN);
  assign loop_enable_o  = (state_q == pmsm_pkg::RUN);
  assign sample_start_o = period_start_i && (state_q == pmsm_pkg::RUN);  // one per period
  assign brake_o        = (state_q != pmsm_pkg::RUN);  // released only in run
  assign fault_o        = (state_q == pmsm_pkg::FAULT);

  // loop opens only after a full driver wake-up window
  a_loop_after_init: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    $rose(loop_enable_o) |-> $past(drv_enable_o, `INIT_CYCLES));

  // once faulted the loop stays shut
  a_fault_sticky: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    fault_o |=> fault_o && !loop_enable_o);

endmodule

// ==== hw/pmsm_params.svh ====
`ifndef PMSM_PARAMS_SVH
`define PMSM_PARAMS_SVH

//======================================================================
// datapath widths and sensor frame
//======================================================================
`define DATA_WIDTH      16     // current, voltage, duty
`define ADC_BITS        12     // sensor code
`define ADC_FRAME_BITS  16     // 4 leading zeros + code, msb first
`define ADC_MIDSCALE    2048   // code at zero current
`define SCLK_HALF       2      // sys clocks per half sclk
`define IMAX_CODE       1500   // overcurrent magnitude limit

//======================================================================
// pwm timing and loop scaling
//======================================================================
`define PWM_PERIOD      200    // clocks per period
`define PWM_HALF        100    // duty for zero volts
`define DEAD_TIME       8      // both switches off per transition
`define GAIN_SHIFT      6      // pi sum scaling
`define INTEG_LIMIT     8000   // integrator clamp, both signs
`define INIT_CYCLES     64     // gate driver wake-up time

`endif

// ==== hw/pmsm_pkg.sv ====
`include "pmsm_params.svh"

package pmsm_pkg;

  typedef logic signed [`DATA_WIDTH-1:0] data_t;  // signed current / voltage
  typedef logic [`DATA_WIDTH-1:0]        duty_t;  // on-time in clocks

  typedef struct packed {
    data_t a;  // phase a
    data_t b;  // phase b
  } phase_current_t;

  typedef struct packed {
    duty_t a;
    duty_t b;
    duty_t c;  // derived from a and b
  } phase_duty_t;

  typedef struct packed {
    logic [7:0] kp;  // proportional gain
    logic [7:0] ki;  // integral gain
  } pi_gain_t;

  typedef struct packed {
    logic a_hi;
    logic a_lo;
    logic b_hi;
    logic b_lo;
    logic c_hi;
    logic c_lo;
  } gate_drive_t;

  typedef enum logic [1:0] {
    IDLE,
    DRIVER_INIT,  // driver enabled, waiting out wake-up
    RUN,
    FAULT         // sticky until reset
  } ctrl_state_e;

endpackage

// ==== hw/pmsm_top.sv ====
`timescale 1ns/1ps

module pmsm_top (
  input  logic                     sys_clk_i,
  input  logic                     reset_i,
  input  pmsm_pkg::phase_current_t current_set_i,  // a/b current demand
  input  pmsm_pkg::pi_gain_t       gains_i,
  input  logic                     adc_a_sdata_i,  // sensor a
  input  logic                     adc_a_ocd_n_i,
  output logic                     adc_a_sclk_o,
  output logic                     adc_a_cs_n_o,
  input  logic                     adc_b_sdata_i,  // sensor b
  input  logic                     adc_b_ocd_n_i,
  output logic                     adc_b_sclk_o,
  output logic                     adc_b_cs_n_o,
  input  logic                     drv_nfault_i,   // gate driver
  output logic                     drv_enable_o,
  output pmsm_pkg::gate_drive_t    gate_o,
  output logic                     brake_o,
  output logic                     fault_o,
  output pmsm_pkg::phase_duty_t    duty_o          // phase timing export
);

  logic                     period_start;
  logic                     sample_start;
  logic                     loop_enable;
  logic                     valid_a;       // both readers run in lockstep
  logic                     oc_a;
  logic                     oc_b;
  logic                     duty_valid;
  pmsm_pkg::data_t          current_a;
  pmsm_pkg::data_t          current_b;
  pmsm_pkg::phase_current_t meas_current;

  assign meas_current.a = current_a;
  assign meas_current.b = current_b;

  //====================================================================
  // sequencing
  //====================================================================
  pmsm_control_unit i_control (
    .sys_clk_i      (sys_clk_i),
    .reset_i        (reset_i),
    .period_start_i (period_start),
    .overcurrent_i  (oc_a || oc_b),
    .drv_nfault_i   (drv_nfault_i),
    .drv_enable_o   (drv_enable_o),
    .loop_enable_o  (loop_enable),
    .sample_start_o (sample_start),
    .brake_o        (brake_o),
    .fault_o        (fault_o)
  );

  //====================================================================
  // current datapath
  //====================================================================
  current_sense_adc i_adc_a (
    .sys_clk_i      (sys_clk_i),
    .reset_i        (reset_i),
    .sample_start_i (sample_start),
    .sdata_i        (adc_a_sdata_i),
    .ocd_n_i        (adc_a_ocd_n_i),
    .sclk_o         (adc_a_sclk_o),
    .cs_n_o         (adc_a_cs_n_o),
    .current_o      (current_a),
    .sample_valid_o (valid_a),
    .overcurrent_o  (oc_a)
  );

  current_sense_adc i_adc_b (
    .sys_clk_i      (sys_clk_i),
    .reset_i        (reset_i),
    .sample_start_i (sample_start),
    .sdata_i        (adc_b_sdata_i),
    .ocd_n_i        (adc_b_ocd_n_i),
    .sclk_o         (adc_b_sclk_o),
    .cs_n_o         (adc_b_cs_n_o),
    .current_o      (current_b),
    .sample_valid_o (),  // same timing as reader a
    .overcurrent_o  (oc_b)
  );

  current_pi_loop i_pi_loop (
    .sys_clk_i      (sys_clk_i),
    .reset_i        (reset_i),
    .loop_enable_i  (loop_enable),
    .sample_valid_i (valid_a),
    .current_i      (meas_current),
    .current_set_i  (current_set_i),
    .gains_i        (gains_i),
    .duty_o         (duty_o),
    .duty_valid_o   (duty_valid)
  );

  pwm_generator i_pwm (
    .sys_clk_i      (sys_clk_i),
    .reset_i        (reset_i),
    .enable_i       (loop_enable),
    .duty_i         (duty_o),
    .duty_valid_i   (duty_valid),
    .gate_o         (gate_o),
    .period_start_o (period_start)
  );

endmodule

// ==== hw/pwm_generator.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module pwm_generator (
  input  logic                  sys_clk_i,
  input  logic                  reset_i,
  input  logic                  enable_i,       // gates forced low when clear
  input  pmsm_pkg::phase_duty_t duty_i,
  input  logic                  duty_valid_i,
  output pmsm_pkg::gate_drive_t gate_o,
  output logic                  period_start_o  // counter at zero
);

  logic [`DATA_WIDTH-1:0] cnt_q;      // 0 .. PWM_PERIOD-1
  pmsm_pkg::phase_duty_t  pending_q;  // next period's duty
  pmsm_pkg::phase_duty_t  active_q;   // duty in force
  logic                   en_q;
  logic [2:0]             demand;     // 0 = a, 1 = b, 2 = c
  logic [2:0]             high;
  logic [2:0]             low;

  assign period_start_o = (cnt_q == '0);

  //====================================================================
  // period counter and duty double buffer
  //====================================================================
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      cnt_q     <= '0;
      pending_q <= {3{pmsm_pkg::duty_t'(`PWM_HALF)}};
      active_q  <= {3{pmsm_pkg::duty_t'(`PWM_HALF)}};
      en_q      <= 1'b0;
    end else begin
      en_q <= enable_i;
      if (cnt_q == `DATA_WIDTH'(`PWM_PERIOD - 1)) begin
        cnt_q    <= '0;
        active_q <= pending_q;  // new duty in force from count 0
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (duty_valid_i)
        pending_q <= duty_i;
    end
  end

  assign demand[0] = (cnt_q < active_q.a);
  assign demand[1] = (cnt_q < active_q.b);
  assign demand[2] = (cnt_q < active_q.c);

  for (genvar p = 0; p < 3; p++) begin : g_phase
    dead_time_inserter i_dead_time (
      .sys_clk_i (sys_clk_i),
      .reset_i   (reset_i),
      .demand_i  (demand[p]),
      .high_o    (high[p]),
      .low_o     (low[p])
    );
  end

  assign gate_o.a_hi = high[0] && en_q;  // all off unless running
  assign gate_o.a_lo = low[0]  && en_q;
  assign gate_o.b_hi = high[1] && en_q;
  assign gate_o.b_lo = low[1]  && en_q;
  assign gate_o.c_hi = high[2] && en_q;
  assign gate_o.c_lo = low[2]  && en_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pmsm current loop testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pmsm_tb \
  -f sim.f -o pmsm_sim \
  && ./obj_dir/pmsm_sim | tee /dev/stderr | grep -q "^TB PASSED$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+hw
hw/pmsm_pkg.sv
hw/pmsm_control_unit.sv
hw/current_sense_adc.sv
hw/current_pi_loop.sv
hw/dead_time_inserter.sv
hw/pwm_generator.sv
hw/pmsm_top.sv
sim/tb_clock_gen.sv
sim/current_sensor_model.sv
sim/pmsm_tb.sv

// ==== sim/current_sensor_model.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module current_sensor_model (
  input  logic                 sclk_i,
  input  logic                 cs_n_i,
  input  logic [`ADC_BITS-1:0] code_i,   // code sent in the next frame
  output logic                 sdata_o
);

  logic [`ADC_FRAME_BITS-1:0] frame_q;  // leading zeros, then the code
  logic [3:0]                 idx_q;    // bit on the wire, msb first

  initial begin
    frame_q = '0;
    idx_q   = 4'd15;
  end

  // code is frozen when the reader selects the sensor
  always @(negedge cs_n_i) begin
    frame_q = {{(`ADC_FRAME_BITS - `ADC_BITS){1'b0}}, code_i};
  end

  // data moves on the falling sclk, reader samples on the rising one
  always @(negedge sclk_i or posedge cs_n_i) begin
    if (cs_n_i)
      idx_q <= 4'd15;
    else if (idx_q != 4'd0)
      idx_q <= idx_q - 4'd1;
  end

  assign sdata_o = !cs_n_i && frame_q[idx_q];  // idle low

endmodule

// ==== sim/pmsm_tb.sv ====
`timescale 1ns/1ps
`include "pmsm_params.svh"

module pmsm_tb;

  localparam int TIMEOUT_CYCLES = (`INIT_CYCLES + 70 * `PWM_PERIOD) * 2;

  logic                     clk;
  logic                     reset;
  pmsm_pkg::phase_current_t current_set;
  pmsm_pkg::pi_gain_t       gains;
  logic                     sdata_a;
  logic                     sdata_b;
  logic                     ocd_n_a;
  logic                     ocd_n_b;
  logic                     sclk_a;
  logic                     sclk_b;
  logic                     cs_n_a;
  logic                     cs_n_b;
  logic                     nfault;
  logic                     drv_en;
  pmsm_pkg::gate_drive_t    gate;
  logic                     brake;
  logic                     fault;
  pmsm_pkg::phase_duty_t    duty;
  logic [`ADC_BITS-1:0]     code_a;
  logic [`ADC_BITS-1:0]     code_b;
  logic [31:0]              lcg_state;
  int                       value_errors;
  int                       gate_errors;
  int                       cycles;
  int                       ref_integ [2];   // reference integrators, a and b
  int                       exp_duty  [3];
  int                       cmp_wait;        // cycles until duty is compared
  int                       checks_done;
  logic                     check_en;
  logic                     cs_n_a_q;

  tb_clock_gen #(.PERIOD_NS(40.0)) i_clk (.clk_o(clk));

  current_sensor_model i_sensor_a (.sclk_i(sclk_a), .cs_n_i(cs_n_a), .code_i(code_a),
                                   .sdata_o(sdata_a));
  current_sensor_model i_sensor_b (.sclk_i(sclk_b), .cs_n_i(cs_n_b), .code_i(code_b),
                                   .sdata_o(sdata_b));

  pmsm_top i_dut (
    .sys_clk_i     (clk),
    .reset_i       (reset),
    .current_set_i (current_set),
    .gains_i       (gains),
    .adc_a_sdata_i (sdata_a),
    .adc_a_ocd_n_i (ocd_n_a),
    .adc_a_sclk_o  (sclk_a),
    .adc_a_cs_n_o  (cs_n_a),
    .adc_b_sdata_i (sdata_b),
    .adc_b_ocd_n_i (ocd_n_b),
    .adc_b_sclk_o  (sclk_b),
    .adc_b_cs_n_o  (cs_n_b),
    .drv_nfault_i  (nfault),
    .drv_enable_o  (drv_en),
    .gate_o        (gate),
    .brake_o       (brake),
    .fault_o       (fault),
    .duty_o        (duty)
  );

  //======================================================================
  // random source and reference model
  //======================================================================
  function automatic int next_rand(input int range);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
    return int'(lcg_state[31:8] % range);  // upper bits are the better ones
  endfunction

  function automatic int pi_volt(input int idx, input int set_val, input int meas,
                                 input int kp, input int ki);
    int err;
    int acc;
    err = set_val - meas;
    acc = ref_integ[idx] + err * ki;
    if (acc > `INTEG_LIMIT)
      acc = `INTEG_LIMIT;
    if (acc < -`INTEG_LIMIT)
      acc = -`INTEG_LIMIT;
    ref_integ[idx] = acc;
    return (err * kp + acc) >>> `GAIN_SHIFT;  // floor division
  endfunction

  function automatic int duty_of(input int volt);
    int d;
    d = `PWM_HALF + volt;
    if (d < 0)
      d = 0;
    if (d > `PWM_PERIOD)
      d = `PWM_PERIOD;
    return d;
  endfunction

  function automatic int high_cycles(input int d);
    if (d >= `PWM_PERIOD)
      return `PWM_PERIOD;  // never switches, high side on all period
    return (d > `DEAD_TIME) ? d - `DEAD_TIME : 0;
  endfunction

  //======================================================================
  // duty comparison, one per sensor frame
  //======================================================================
  always @(posedge clk) begin
    int va;
    int vb;
    if (reset) begin
      cmp_wait = 0;
      for (int p = 0; p < 3; p++)
        exp_duty[p] = `PWM_HALF;  // zero volts out of reset
    end else if (cs_n_a && !cs_n_a_q) begin  // frame just ended
      va = pi_volt(0, int'(current_set.a), int'(code_a) - `ADC_MIDSCALE,
                   int'(gains.kp), int'(gains.ki));
      vb = pi_volt(1, int'(current_set.b), int'(code_b) - `ADC_MIDSCALE,
                   int'(gains.kp), int'(gains.ki));
      exp_duty[0] = duty_of(va);
      exp_duty[1] = duty_of(vb);
      exp_duty[2] = duty_of(-(va + vb));  // phase c closes the sum
      cmp_wait = check_en ? 3 : 0;  // model follows every frame
    end else if (cmp_wait > 0) begin
      cmp_wait = cmp_wait - 1;
      if (cmp_wait == 0) begin
        assert (int'(duty.a) == exp_duty[0] && int'(duty.b) == exp_duty[1] &&
                int'(duty.c) == exp_duty[2])
        else begin
          $display("FAILED at %0t: duty %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
                   duty.a, duty.b, duty.c, exp_duty[0], exp_duty[1], exp_duty[2]);
          value_errors++;
        end
        checks_done++;
      end
    end
    cs_n_a_q = cs_n_a;
  end

  //======================================================================
  // gate monitor
  //======================================================================
  int   off_cnt   [3];
  int   hi_cnt    [3];
  int   act_duty  [3];
  int   prev_duty [3];
  logic prev_hi   [3];
  logic prev_lo   [3];
  int   ph;         // pwm count of the sampled cycle
  int   run_len;

  always @(posedge clk) begin
    logic [2:0] hi_v;
    logic [2:0] lo_v;
    hi_v = {gate.c_hi, gate.b_hi, gate.a_hi};
    lo_v = {gate.c_lo, gate.b_lo, gate.a_lo};
    ph      = reset ? `PWM_PERIOD - 1 : (ph + 1) % `PWM_PERIOD;
    run_len = brake ? 0 : run_len + 1;
    for (int p = 0; p < 3; p++) begin
      if (reset) begin
        off_cnt[p] = 0;  // gates masked until the loop runs
      end else begin
        assert (!(hi_v[p] && lo_v[p]))
        else begin
          $display("FAILED at %0t: phase %0d has both switches on", $time, p);
          gate_errors++;
        end
        if (!hi_v[p] && !lo_v[p]) begin
          off_cnt[p]++;
        end else begin
          if (!prev_hi[p] && !prev_lo[p]) begin
            assert (off_cnt[p] >= `DEAD_TIME)
            else begin
              $display("FAILED at %0t: phase %0d dead time %0d cycles", $time, p,
                       off_cnt[p]);
              gate_errors++;
            end
          end else begin
            assert (hi_v[p] == prev_hi[p])
            else begin
              $display("FAILED at %0t: phase %0d switched sides with no gap", $time, p);
              gate_errors++;
            end
          end
          off_cnt[p] = 0;
        end
      end
      prev_hi[p] = hi_v[p];
      prev_lo[p] = lo_v[p];
      if (ph == 0)
        hi_cnt[p] = 0;
      if (hi_v[p])
        hi_cnt[p]++;
    end
    if (reset) begin
      for (int p = 0; p < 3; p++) begin
        act_duty[p]  = `PWM_HALF;
        prev_duty[p] = -1;
      end
    end else if (ph == `PWM_PERIOD - 1) begin
      for (int p = 0; p < 3; p++) begin
        if (run_len > `PWM_PERIOD + 1 && act_duty[p] == prev_duty[p]) begin  // steady period
          assert (hi_cnt[p] == high_cycles(act_duty[p]))
          else begin
            $display("FAILED at %0t: phase %0d high for %0d cycles at duty %0d", $time, p,
                     hi_cnt[p], act_duty[p]);
            gate_errors++;
          end
        end
        prev_duty[p] = act_duty[p];
      end
      act_duty[0] = exp_duty[0];  // loaded at the coming period start
      act_duty[1] = exp_duty[1];
      act_duty[2] = exp_duty[2];
    end
  end

  //======================================================================
  // timeout
  //======================================================================
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  //======================================================================
  // stimulus
  //======================================================================
  task automatic power_up;
    int wait_cnt;
    reset  <= 1'b1;
    nfault <= 1'b1;
    repeat (8) @(posedge clk);
    reset       <= 1'b0;
    ref_integ[0] = 0;  // loop integrators clear outside run
    ref_integ[1] = 0;
    @(posedge clk);  // still idle, power-up starts on this edge
    assert (gate == '0 && !drv_en && brake && !fault)
    else begin
      $display("FAILED at %0t: outputs not idle after reset", $time);
      value_errors++;
    end
    while (!drv_en)
      @(posedge clk);
    wait_cnt = 0;
    while (brake) begin
      @(posedge clk);
      wait_cnt++;
    end
    assert (wait_cnt >= `INIT_CYCLES && drv_en)
    else begin
      $display("FAILED at %0t: brake released after %0d driver cycles", $time, wait_cnt);
      value_errors++;
    end
  endtask

  task automatic randomize_inputs;
    int r;
    r = next_rand(2 * `IMAX_CODE - 1);
    code_a <= `ADC_BITS'(`ADC_MIDSCALE - (`IMAX_CODE - 1) + r);  // inside the limit
    r = next_rand(2 * `IMAX_CODE - 1);
    code_b <= `ADC_BITS'(`ADC_MIDSCALE - (`IMAX_CODE - 1) + r);
    r = next_rand(401);
    current_set.a <= pmsm_pkg::data_t'(r - 200);
    r = next_rand(401);
    current_set.b <= pmsm_pkg::data_t'(r - 200);
    r = next_rand(32);
    gains.kp <= 8'(r);
    r = next_rand(16);
    gains.ki <= 8'(r);
  endtask

  task automatic check_fault_response;
    while (!fault)
      @(posedge clk);
    assert (brake && !drv_en)
    else begin
      $display("FAILED at %0t: brake or driver enable wrong in fault", $time);
      value_errors++;
    end
    repeat (2) @(posedge clk);
    repeat (2 * `PWM_PERIOD) begin
      assert (gate == '0 && fault)
      else begin
        $display("FAILED at %0t: gates on while faulted", $time);
        gate_errors++;
      end
      @(posedge clk);
    end
  endtask

  initial begin
    reset        = 1'b1;  // all dut inputs defined from time zero
    nfault       = 1'b1;
    ocd_n_a      = 1'b1;
    ocd_n_b      = 1'b1;
    current_set  = '0;
    gains        = '0;
    code_a       = `ADC_BITS'(`ADC_MIDSCALE);
    code_b       = `ADC_BITS'(`ADC_MIDSCALE);
    lcg_state    = 32'h6689;
    value_errors = 0;
    gate_errors  = 0;
    cycles       = 0;
    checks_done  = 0;
    check_en     = 1'b0;
    @(posedge clk);
    randomize_inputs();
    power_up();
    check_en = 1'b1;
    // random currents, gains and set values
    for (int n = 0; n < 40; n++) begin
      while (checks_done < n + 1)
        @(posedge clk);
      randomize_inputs();
    end
    // large demand drives the duties into the clamp
    while (checks_done < 41)
      @(posedge clk);
    code_a        <= `ADC_BITS'(`ADC_MIDSCALE);
    code_b        <= `ADC_BITS'(`ADC_MIDSCALE);
    current_set.a <= pmsm_pkg::data_t'(1000);
    current_set.b <= pmsm_pkg::data_t'(-1000);
    gains         <= '{kp: 8'd255, ki: 8'd40};
    while (checks_done < 47)
      @(posedge clk);
    assert (int'(duty.a) == `PWM_PERIOD && int'(duty.b) == 0)
    else begin
      $display("FAILED at %0t: duty %0d/%0d not saturated", $time, duty.a, duty.b);
      value_errors++;
    end
    // sensor code past the overcurrent limit
    check_en = 1'b0;
    code_a <= `ADC_BITS'(`ADC_MIDSCALE + `IMAX_CODE + 100);
    check_fault_response();
    // driver fault, then a fresh reset
    code_a <= `ADC_BITS'(`ADC_MIDSCALE);
    power_up();
    repeat (`PWM_PERIOD) @(posedge clk);
    nfault <= 1'b0;
    check_fault_response();
    power_up();
    repeat (`PWM_PERIOD) @(posedge clk);
    $display("errors: value %0d, gate %0d", value_errors, gate_errors);
    if (value_errors + gate_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 40.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = !clk_o;  // free running
  end

endmodule
